//--- design/aes_bridge_pkg.sv
// shared types and constants for the byte-serial cipher bridge
// every bridge module and the testbench refer to these by scoped name
package aes_bridge_pkg;

	// ----------------------------------------
	// data types
	// ----------------------------------------
	typedef logic [7:0]  byte_t;   // one key, plaintext or cipher byte
	typedef logic [31:0] word_t;   // register data or address word
	typedef logic [4:0]  count_t;  // queue occupancy, 0 to 16 inclusive

	// bytes per 128-bit block, also the depth of each queue
	localparam int block_bytes = 16;

	// ----------------------------------------
	// register map
	// ----------------------------------------
	localparam word_t fifo_addr   = 32'h0000_0510;  // key/text writes, cipher reads
	localparam word_t status_addr = 32'h0000_0514;  // done and empty flags

	// sequencer phases, in the order a block walks through them
	typedef enum logic [2:0]
	{
		collect_key,   // host writes land in the key queue
		collect_text,  // host writes land in the plaintext queue
		feed_core,     // sixteen byte pairs go out back to back
		wait_cipher,   // core is working, cipher bytes trickle in
		cipher_ready   // host drains the cipher queue
	} seq_state_t;

endpackage

//--- design/byte_fifo.sv
// sixteen-entry fall-through byte queue
// head always shows the oldest byte, a pop retires it at the clock edge
// pushes into a full queue and pops from an empty one are ignored
`timescale 1ns/100ps

module byte_fifo
(
	input  logic                  clk_main_a0,
	input  logic                  rst_main_n_sync,
	input  logic                  push,       // store push_data at the edge
	input  aes_bridge_pkg::byte_t push_data,
	input  logic                  pop,        // retire head at the edge
	output aes_bridge_pkg::byte_t head,       // oldest byte, no read latency
	output logic                  empty,
	output logic                  full
);

	aes_bridge_pkg::byte_t mem [aes_bridge_pkg::block_bytes];  // storage array
	logic [$clog2(aes_bridge_pkg::block_bytes)-1:0] wr_ptr;    // next free slot
	logic [$clog2(aes_bridge_pkg::block_bytes)-1:0] rd_ptr;    // oldest entry
	aes_bridge_pkg::count_t count;                              // occupancy
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;   // overflow is dropped silently
	assign do_pop  = pop && !empty;   // underflow does nothing

	assign full  = (count == aes_bridge_pkg::count_t'(aes_bridge_pkg::block_bytes));
	assign empty = (count == '0);
	assign head  = mem[rd_ptr];       // fall-through read

	// ----------------------------------------
	// storage
	// ----------------------------------------
	always_ff @(posedge clk_main_a0)
	begin
		if (do_push)
		begin
			mem[wr_ptr] <= push_data;
		end
	end

	// ----------------------------------------
	// pointers and occupancy
	// ----------------------------------------
	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
			begin
				wr_ptr <= wr_ptr + 1'b1;  // wraps at sixteen
			end
			if (do_pop)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + aes_bridge_pkg::count_t'(1);
				2'b01:   count <= count - aes_bridge_pkg::count_t'(1);
				default: count <= count;  // idle, or push and pop together
			endcase
		end
	end

endmodule

//--- design/bridge_sequencer.sv
// block sequencer of the cipher bridge
// routes host writes into the key and plaintext queues, streams both queues
// into the cipher core on sixteen back-to-back cycles, then collects the
// sixteen returned bytes into the cipher queue and waits for them to drain
`timescale 1ns/100ps

module bridge_sequencer
(
	input  logic                  clk_main_a0,
	input  logic                  rst_main_n_sync,
	// host write channel
	input  logic                  wready,        // write strobe
	input  aes_bridge_pkg::word_t wr_addr,
	input  aes_bridge_pkg::word_t wdata,
	// input queue status and heads
	input  logic                  key_full,
	input  logic                  text_full,
	input  aes_bridge_pkg::byte_t key_head,
	input  aes_bridge_pkg::byte_t text_head,
	// core return path
	input  logic                  core_out_valid,
	input  aes_bridge_pkg::byte_t core_out_byte,
	input  logic                  cipher_empty,
	// queue controls
	output logic                  key_push,
	output logic                  text_push,
	output aes_bridge_pkg::byte_t push_byte,     // shared by key and text queues
	output logic                  feed_pop,      // pops key and text together
	output logic                  cipher_push,
	output aes_bridge_pkg::byte_t cipher_byte,
	// core feed
	output logic                  core_enable,
	output logic                  core_in_valid,
	output aes_bridge_pkg::byte_t core_key_byte,
	output aes_bridge_pkg::byte_t core_data_byte,
	// to the read port
	output logic                  cipher_done
);

	aes_bridge_pkg::seq_state_t state;
	aes_bridge_pkg::seq_state_t state_next;
	aes_bridge_pkg::count_t     byte_cnt;       // feed pairs or cipher bytes so far
	aes_bridge_pkg::count_t     byte_cnt_next;
	logic                       wr_hit;         // strobed write to the data register
	logic                       last_byte;      // counter on the sixteenth byte

	assign wr_hit    = wready && (wr_addr == aes_bridge_pkg::fifo_addr);
	assign last_byte = (byte_cnt == aes_bridge_pkg::count_t'(aes_bridge_pkg::block_bytes - 1));

	// ----------------------------------------
	// next state and byte counter
	// ----------------------------------------
	always_comb
	begin
		state_next    = state;
		byte_cnt_next = byte_cnt;
		case (state)
			aes_bridge_pkg::collect_key:
			begin
				if (key_full)                        // sixteen key bytes held
				begin
					state_next = aes_bridge_pkg::collect_text;
				end
			end
			aes_bridge_pkg::collect_text:
			begin
				if (text_full)
				begin
					state_next = aes_bridge_pkg::feed_core;
				end
			end
			aes_bridge_pkg::feed_core:
			begin
				// one pair per cycle, no gaps
				if (last_byte)
				begin
					state_next    = aes_bridge_pkg::wait_cipher;
					byte_cnt_next = '0;
				end
				else
				begin
					byte_cnt_next = byte_cnt + aes_bridge_pkg::count_t'(1);
				end
			end
			aes_bridge_pkg::wait_cipher:
			begin
				if (core_out_valid)                  // count only the valid pulses
				begin
					if (last_byte)
					begin
						state_next    = aes_bridge_pkg::cipher_ready;
						byte_cnt_next = '0;
					end
					else
					begin
						byte_cnt_next = byte_cnt + aes_bridge_pkg::count_t'(1);
					end
				end
			end
			aes_bridge_pkg::cipher_ready:
			begin
				if (cipher_empty)                    // last byte was read out
				begin
					state_next = aes_bridge_pkg::collect_key;
				end
			end
			default:
			begin
				state_next    = aes_bridge_pkg::collect_key;
				byte_cnt_next = '0;
			end
		endcase
	end

	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			state    <= aes_bridge_pkg::collect_key;
			byte_cnt <= '0;
		end
		else
		begin
			state    <= state_next;
			byte_cnt <= byte_cnt_next;
		end
	end

	// ----------------------------------------
	// queue and core controls
	// ----------------------------------------
	// writes outside the two collect phases, or into a full queue, are lost
	assign key_push  = wr_hit && (state == aes_bridge_pkg::collect_key) && !key_full;
	assign text_push = wr_hit && (state == aes_bridge_pkg::collect_text) && !text_full;
	assign push_byte = wdata[7:0];                   // low byte carries the payload

	assign feed_pop       = (state == aes_bridge_pkg::feed_core);
	assign core_in_valid  = (state == aes_bridge_pkg::feed_core);
	assign core_key_byte  = key_head;                // fall-through heads go straight out
	assign core_data_byte = text_head;

	// core stays enabled from the first feed byte to the last stored cipher byte
	assign core_enable = (state == aes_bridge_pkg::feed_core) ||
		(state == aes_bridge_pkg::wait_cipher);

	assign cipher_push = core_out_valid && (state == aes_bridge_pkg::wait_cipher);
	assign cipher_byte = core_out_byte;
	assign cipher_done = (state == aes_bridge_pkg::cipher_ready);

endmodule

//--- design/read_port.sv
// register read channel of the bridge
// a data register read pops one cipher byte once the block is done,
// every other address returns the status word
// one request in flight, response held until the host takes it
`timescale 1ns/100ps

module read_port
(
	input  logic                  clk_main_a0,
	input  logic                  rst_main_n_sync,
	input  logic                  arvalid_q,     // read request
	input  aes_bridge_pkg::word_t araddr_q,
	input  logic                  rready,        // host takes the response
	input  aes_bridge_pkg::byte_t cipher_head,
	input  logic                  cipher_empty,
	input  logic                  cipher_done,   // block complete, bytes readable
	output logic                  arready,
	output logic                  rvalid,
	output aes_bridge_pkg::word_t rdata,
	output logic                  cipher_pop
);

	logic                  rd_accept;   // request taken this edge
	logic                  data_sel;    // request targets the data register
	aes_bridge_pkg::word_t rsp_word;    // response captured at acceptance

	assign arready   = !rvalid;                  // free again once the response is taken
	assign rd_accept = arvalid_q && arready;
	assign data_sel  = (araddr_q == aes_bridge_pkg::fifo_addr);

	// pop only when there is a finished byte to hand out
	assign cipher_pop = rd_accept && data_sel && cipher_done && !cipher_empty;

	// ----------------------------------------
	// response select
	// ----------------------------------------
	always_comb
	begin
		if (data_sel)
		begin
			if (cipher_pop)
			begin
				rsp_word = {24'h0, cipher_head};   // zero-extended cipher byte
			end
			else
			begin
				rsp_word = '0;                      // early or stray data read
			end
		end
		else
		begin
			rsp_word = {30'h0, cipher_empty, cipher_done};  // status word
		end
	end

	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			rvalid <= 1'b0;
		end
		else if (rd_accept)
		begin
			rvalid <= 1'b1;
		end
		else if (rready)
		begin
			rvalid <= 1'b0;       // handshake done
		end
	end

	// data only moves on acceptance, so it stays put while rready is low
	always_ff @(posedge clk_main_a0)
	begin
		if (rd_accept)
		begin
			rdata <= rsp_word;
		end
	end

endmodule

//--- design/aes_bridge_top.sv
// top level of the byte-serial cipher bridge
// ties the key, plaintext and cipher queues to the sequencer and read port
// the cipher core sits outside, its byte ports are brought out here
`timescale 1ns/100ps

module aes_bridge_top
(
	input  logic                  clk_main_a0,
	input  logic                  rst_main_n_sync,
	// host write side
	input  logic                  wready,
	input  aes_bridge_pkg::word_t wr_addr,
	input  aes_bridge_pkg::word_t wdata,
	// host read side
	input  logic                  arvalid_q,
	input  aes_bridge_pkg::word_t araddr_q,
	input  logic                  rready,
	output logic                  arready,
	output logic                  rvalid,
	output aes_bridge_pkg::word_t rdata,
	// cipher core
	output logic                  core_enable,
	output logic                  core_in_valid,
	output aes_bridge_pkg::byte_t core_key_byte,
	output aes_bridge_pkg::byte_t core_data_byte,
	input  logic                  core_out_valid,
	input  aes_bridge_pkg::byte_t core_out_byte
);

	// ----------------------------------------
	// internal nets
	// ----------------------------------------
	logic                  key_push;
	logic                  text_push;
	aes_bridge_pkg::byte_t push_byte;      // same byte offered to both input queues
	logic                  feed_pop;       // key and text popped in lockstep
	aes_bridge_pkg::byte_t key_head;
	aes_bridge_pkg::byte_t text_head;
	logic                  key_full;
	logic                  text_full;
	logic                  cipher_push;
	aes_bridge_pkg::byte_t cipher_byte;
	logic                  cipher_pop;
	aes_bridge_pkg::byte_t cipher_head;
	logic                  cipher_empty;
	logic                  cipher_done;

	byte_fifo key_fifo
	(
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.push            (key_push),
		.push_data       (push_byte),
		.pop             (feed_pop),
		.head            (key_head),
		.empty           (),                 // phase is tracked by the sequencer
		.full            (key_full)
	);

	byte_fifo text_fifo
	(
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.push            (text_push),
		.push_data       (push_byte),
		.pop             (feed_pop),
		.head            (text_head),
		.empty           (),
		.full            (text_full)
	);

	byte_fifo cipher_fifo
	(
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.push            (cipher_push),
		.push_data       (cipher_byte),
		.pop             (cipher_pop),
		.head            (cipher_head),
		.empty           (cipher_empty),
		.full            ()                  // never more than one block in flight
	);

	bridge_sequencer u_sequencer
	(
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.wready          (wready),
		.wr_addr         (wr_addr),
		.wdata           (wdata),
		.key_full        (key_full),
		.text_full       (text_full),
		.key_head        (key_head),
		.text_head       (text_head),
		.core_out_valid  (core_out_valid),
		.core_out_byte   (core_out_byte),
		.cipher_empty    (cipher_empty),
		.key_push        (key_push),
		.text_push       (text_push),
		.push_byte       (push_byte),
		.feed_pop        (feed_pop),
		.cipher_push     (cipher_push),
		.cipher_byte     (cipher_byte),
		.core_enable     (core_enable),
		.core_in_valid   (core_in_valid),
		.core_key_byte   (core_key_byte),
		.core_data_byte  (core_data_byte),
		.cipher_done     (cipher_done)
	);

	read_port u_read_port
	(
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.arvalid_q       (arvalid_q),
		.araddr_q        (araddr_q),
		.rready          (rready),
		.cipher_head     (cipher_head),
		.cipher_empty    (cipher_empty),
		.cipher_done     (cipher_done),
		.arready         (arready),
		.rvalid          (rvalid),
		.rdata           (rdata),
		.cipher_pop      (cipher_pop)
	);

endmodule

//--- verif/cipher_core_model.sv
// behavioral byte-serial cipher core for the bridge testbench
// takes sixteen key and data byte pairs, then after a random delay returns
// key ^ data ^ index for each index, one pulse per byte with random idle gaps
`timescale 1ns/100ps

module cipher_core_model
(
	input  logic                  clk_main_a0,
	input  logic                  rst_main_n_sync,
	input  logic                  core_enable,
	input  logic                  core_in_valid,
	input  aes_bridge_pkg::byte_t core_key_byte,
	input  aes_bridge_pkg::byte_t core_data_byte,
	output logic                  core_out_valid,
	output aes_bridge_pkg::byte_t core_out_byte
);

	aes_bridge_pkg::byte_t pair_xor [aes_bridge_pkg::block_bytes];  // key ^ data per index
	int                    n_in;   // pairs captured so far
	int                    idx;
	int                    gap;    // idle cycles after a cipher byte

	initial
	begin
		core_out_valid = 1'b0;
		core_out_byte  = '0;
		wait (rst_main_n_sync === 1'b1);
		forever
		begin
			n_in = 0;
			while (n_in < aes_bridge_pkg::block_bytes)
			begin
				@(negedge clk_main_a0);                  // heads are settled mid-cycle
				if (core_in_valid && core_enable)
				begin
					pair_xor[n_in] = core_key_byte ^ core_data_byte;
					n_in++;
				end
			end
			repeat ($urandom_range(1, 8)) @(posedge clk_main_a0);  // core latency
			#1;
			for (idx = 0; idx < aes_bridge_pkg::block_bytes; idx++)
			begin
				core_out_valid = 1'b1;
				core_out_byte  = pair_xor[idx] ^ aes_bridge_pkg::byte_t'(idx);
				@(posedge clk_main_a0);
				#1;
				gap = $urandom_range(0, 2);
				if (gap != 0)
				begin
					core_out_valid = 1'b0;
					repeat (gap) @(posedge clk_main_a0);
					#1;
				end
			end
			core_out_valid = 1'b0;                      // block done, back to idle
		end
	end

endmodule

//--- verif/aes_bridge_tb.sv
// testbench for the cipher bridge
// pushes three back-to-back blocks of random key and plaintext bytes through
// the bridge and a behavioral core, checks each cipher read against a
// reference model, with stray writes, early reads and held responses mixed in
`timescale 1ns/100ps

module aes_bridge_tb;

	localparam int blocks       = 3;
	localparam int block_budget = 660;   // worst case for one block plus stray traffic
	localparam int cycle_limit  = 2 * blocks * block_budget + 40;  // 4000 cycles

	logic                  clk_main_a0;
	logic                  rst_main_n_sync;
	logic                  wready;
	aes_bridge_pkg::word_t wr_addr;
	aes_bridge_pkg::word_t wdata;
	logic                  arvalid_q;
	aes_bridge_pkg::word_t araddr_q;
	logic                  rready;
	logic                  arready;
	logic                  rvalid;
	aes_bridge_pkg::word_t rdata;
	logic                  core_enable;
	logic                  core_in_valid;
	aes_bridge_pkg::byte_t core_key_byte;
	aes_bridge_pkg::byte_t core_data_byte;
	logic                  core_out_valid;
	aes_bridge_pkg::byte_t core_out_byte;

	int                    errors = 0;
	int                    checks = 0;
	int                    cycle_count = 0;
	aes_bridge_pkg::byte_t key_bytes  [aes_bridge_pkg::block_bytes];  // as written, in order
	aes_bridge_pkg::byte_t text_bytes [aes_bridge_pkg::block_bytes];
	aes_bridge_pkg::word_t rd_word;

	aes_bridge_top DUT (.*);
	cipher_core_model u_core (.*);

	initial
	begin
		clk_main_a0 = 1'b0;
		forever #2 clk_main_a0 = ~clk_main_a0;   // 4 ns period
	end

	// ----------------------------------------
	// run limit
	// ----------------------------------------
	always @(posedge clk_main_a0)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == cycle_limit)
		begin
			$display("timeout: bridge did not finish within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic tick();
		@(posedge clk_main_a0);
		#1;                                      // inputs change just after the edge
	endtask

	task automatic check(input string name, input aes_bridge_pkg::word_t expected,
		input aes_bridge_pkg::word_t actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic write_reg(input aes_bridge_pkg::word_t addr, input aes_bridge_pkg::word_t data);
		repeat ($urandom_range(0, 3)) tick();    // random gap between strobes
		wready  = 1'b1;
		wr_addr = addr;
		wdata   = data;
		tick();
		wready  = 1'b0;
	endtask

	// one read request, response held for a random number of cycles
	task automatic read_reg(input aes_bridge_pkg::word_t addr, output aes_bridge_pkg::word_t data);
		aes_bridge_pkg::word_t held;
		while (!arready) tick();
		arvalid_q = 1'b1;
		araddr_q  = addr;
		tick();
		arvalid_q = 1'b0;
		while (!rvalid) tick();
		held = rdata;
		repeat ($urandom_range(0, 3))
		begin
			tick();
			check("rvalid_held", 32'd1, rvalid);   // response must not drop early
			check("rdata_held", held, rdata);
		end
		rready = 1'b1;
		tick();
		rready = 1'b0;
		data = held;
	endtask

	// ----------------------------------------
	// one block: load, wait, drain, compare
	// ----------------------------------------
	task automatic run_block(input int blk, input bit stray);
		aes_bridge_pkg::word_t junk;
		aes_bridge_pkg::word_t st;
		aes_bridge_pkg::byte_t expect_byte;
		int i;
		for (i = 0; i < aes_bridge_pkg::block_bytes; i++)
		begin
			key_bytes[i]  = $urandom;
			text_bytes[i] = $urandom;
		end
		for (i = 0; i < aes_bridge_pkg::block_bytes; i++)
		begin
			junk = $urandom;
			if (stray && junk[1:0] == 2'b00)
			begin
				write_reg(aes_bridge_pkg::fifo_addr + 32'h10, junk);  // wrong address
			end
			write_reg(aes_bridge_pkg::fifo_addr, {junk[31:8], key_bytes[i]});  // upper bits ignored
		end
		tick();   // sequencer leaves key collection on the edge after the queue fills
		if (stray)
		begin
			read_reg(aes_bridge_pkg::fifo_addr, rd_word);   // too early, no pop
			check("early_data_read", 32'h0, rd_word);
			read_reg(aes_bridge_pkg::status_addr, rd_word);
			check("early_status", 32'h2, rd_word);
		end
		for (i = 0; i < aes_bridge_pkg::block_bytes; i++)
		begin
			junk = $urandom;
			write_reg(aes_bridge_pkg::fifo_addr, {junk[31:8], text_bytes[i]});
		end
		for (i = 0; stray && i < 3; i++)
		begin
			write_reg(aes_bridge_pkg::fifo_addr, $urandom);  // queue full, must be dropped
		end
		if (stray)
		begin
			// first cipher byte lands in the queue at this edge, block not done yet
			do
			begin
				@(posedge clk_main_a0);
			end
			while (core_out_valid !== 1'b1);
			#1;
			read_reg(aes_bridge_pkg::fifo_addr, rd_word);   // queued byte must survive
			check("mid_cipher_data_read", 32'h0, rd_word);
		end
		do
		begin
			read_reg(aes_bridge_pkg::status_addr, st);
		end
		while (st[0] == 1'b0);
		check($sformatf("block%0d_status_ready", blk), 32'h1, st);
		check($sformatf("block%0d_core_released", blk), 32'd0, core_enable);
		for (i = 0; i < aes_bridge_pkg::block_bytes; i++)
		begin
			expect_byte = key_bytes[i] ^ text_bytes[i] ^ aes_bridge_pkg::byte_t'(i);
			read_reg(aes_bridge_pkg::fifo_addr, rd_word);
			check($sformatf("block%0d_byte%0d", blk, i), {24'h0, expect_byte}, rd_word);
		end
		read_reg(aes_bridge_pkg::status_addr, st);      // back in key collection
		check($sformatf("block%0d_status_drained", blk), 32'h2, st);
	endtask

	initial
	begin
		int blk;
		void'($urandom(32'ha7829c41));
		wready          = 1'b0;
		wr_addr         = '0;
		wdata           = '0;
		arvalid_q       = 1'b0;
		araddr_q        = '0;
		rready          = 1'b0;
		rst_main_n_sync = 1'b0;
		repeat (4) @(posedge clk_main_a0);
		#1;
		rst_main_n_sync = 1'b1;
		check("reset_arready", 32'd1, arready);
		check("reset_core_enable", 32'd0, core_enable);
		check("reset_core_in_valid", 32'd0, core_in_valid);
		read_reg(aes_bridge_pkg::status_addr, rd_word);
		check("reset_status", 32'h2, rd_word);  // not done, cipher queue empty
		for (blk = 0; blk < blocks; blk++)
		begin
			run_block(blk, blk != 1);            // middle block runs without stray traffic
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- build.f
design/aes_bridge_pkg.sv
design/byte_fifo.sv
design/bridge_sequencer.sv
design/read_port.sv
design/aes_bridge_top.sv
verif/cipher_core_model.sv
verif/aes_bridge_tb.sv

//--- Bender.yml
package:
  name: aes_bridge

sources:
  - design/aes_bridge_pkg.sv
  - design/byte_fifo.sv
  - design/bridge_sequencer.sv
  - design/read_port.sv
  - design/aes_bridge_top.sv
  - target: test
    files:
      - verif/cipher_core_model.sv
      - verif/aes_bridge_tb.sv
